//--- logic/execPkg.sv
package execPkg;

	////////////////////////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////////////////////////

	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int regIdxWidth = $clog2(regCount);
	localparam int immWidth = 8;

	typedef logic [dataWidth-1:0] dataWord_t;
	typedef logic [regIdxWidth-1:0] regIdx_t;

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////

	typedef enum logic [7:0]
	{
		// Adds, signed and unsigned, with and without carry
		ADD    = 8'b00000101,
		ADDI   = 8'b01010000,
		ADDU   = 8'b00000110,
		ADDUI  = 8'b01100000,
		ADDC   = 8'b00000111,
		ADDCI  = 8'b01110000,
		ADDCU  = 8'b00000100,
		ADDCUI = 8'b01000000,
		// Subtract and compares
		SUB    = 8'b00001001,
		SUBI   = 8'b10010000,
		CMP    = 8'b00001011,
		CMPI   = 8'b10110000,
		CMPU   = 8'b00001000,
		CMPUI  = 8'b00001100,
		// Bitwise logic
		AND    = 8'b00000001,
		ANDI   = 8'b00010000,
		OR     = 8'b00000010,
		ORI    = 8'b00100000,
		XOR    = 8'b00000011,
		XORI   = 8'b00110000,
		NOT    = 8'b00001111,
		// Shifts, count taken from operand B
		LSH    = 8'b10000100,
		LSHI   = 8'b10000000,
		RSH    = 8'b10000101,
		RSHI   = 8'b10000001,
		ALSH   = 8'b10000110,
		ALSHI  = 8'b10000010,
		ARSH   = 8'b10000111,
		ARSHI  = 8'b10000011,
		NOP    = 8'b00000000
	} opcode_t;

	////////////////////////////////////////////////////////////
	// Flags and packets
	////////////////////////////////////////////////////////////

	// Bit 4 down to bit 0
	typedef struct packed
	{
		logic zero;
		logic carry;
		logic overflow;
		logic low;
		logic negative;
	} flags_t;

	typedef struct packed
	{
		opcode_t opcode;
		regIdx_t rDest;
		regIdx_t rSrc;
		logic [immWidth-1:0] imm;
	} instrPkt_t;

	// Reported back with the acknowledge
	typedef struct packed
	{
		dataWord_t value;
		flags_t flags;
		logic wrote;
	} resultPkt_t;

endpackage

//--- logic/alu.sv
module alu
(
	input  execPkg::dataWord_t a,
	input  execPkg::dataWord_t b,
	input  logic carryIn,
	input  execPkg::opcode_t opcode,
	output execPkg::dataWord_t result,
	output execPkg::flags_t flags
);

	logic useCarry;
	logic [execPkg::dataWidth:0] sum;
	execPkg::dataWord_t diff;
	logic addOverflow;
	logic subOverflow;
	logic setsZero;

	////////////////////////////////////////////////////////////
	// Shared adder and subtractor
	////////////////////////////////////////////////////////////

	assign useCarry = opcode inside {execPkg::ADDC, execPkg::ADDCI,
		execPkg::ADDCU, execPkg::ADDCUI};

	// Extra top bit holds the unsigned carry out
	assign sum = {1'b0, a} + {1'b0, b}
		+ (execPkg::dataWidth+1)'(carryIn & useCarry);

	assign diff = a - b;

	// Overflow when the operand signs match and the result sign flips
	assign addOverflow = (a[execPkg::dataWidth-1] == b[execPkg::dataWidth-1])
		&& (sum[execPkg::dataWidth-1] != a[execPkg::dataWidth-1]);

	// Opposite operand signs for a subtract
	assign subOverflow = (a[execPkg::dataWidth-1] != b[execPkg::dataWidth-1])
		&& (diff[execPkg::dataWidth-1] != a[execPkg::dataWidth-1]);

	////////////////////////////////////////////////////////////
	// Result and flags per opcode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		// NOP and unknown opcodes keep these zero defaults
		result = '0;
		flags = '0;
		setsZero = 1'b0;

		case (opcode)
			execPkg::ADD, execPkg::ADDI, execPkg::ADDC, execPkg::ADDCI:
			begin
				result = sum[execPkg::dataWidth-1:0];
				flags.overflow = addOverflow;
				setsZero = 1'b1;
			end
			execPkg::ADDU, execPkg::ADDUI, execPkg::ADDCU, execPkg::ADDCUI:
			begin
				result = sum[execPkg::dataWidth-1:0];
				flags.carry = sum[execPkg::dataWidth];
				setsZero = 1'b1;
			end
			execPkg::SUB, execPkg::SUBI:
			begin
				result = diff;
				flags.overflow = subOverflow;
				setsZero = 1'b1;
			end
			// Compares report zero and only set low and negative
			execPkg::CMP, execPkg::CMPI:
			begin
				if ($signed(a) < $signed(b))
				begin
					flags.low = 1'b1;
					flags.negative = 1'b1;
				end
			end
			execPkg::CMPU, execPkg::CMPUI:
			begin
				if (a < b)
				begin
					flags.low = 1'b1;
					flags.negative = 1'b1;
				end
			end
			execPkg::AND, execPkg::ANDI:
			begin
				result = a & b;
				setsZero = 1'b1;
			end
			execPkg::OR, execPkg::ORI:
			begin
				result = a | b;
				setsZero = 1'b1;
			end
			execPkg::XOR, execPkg::XORI:
			begin
				result = a ^ b;
				setsZero = 1'b1;
			end
			execPkg::NOT:
			begin
				result = ~a;
				setsZero = 1'b1;
			end
			// Counts of 16 and up give 0, or sign fill for ARSH
			// Logical and arithmetic left shifts move the same bits
			execPkg::LSH, execPkg::LSHI, execPkg::ALSH, execPkg::ALSHI:
			begin
				result = a << b;
			end
			execPkg::RSH, execPkg::RSHI:
			begin
				result = a >> b;
			end
			execPkg::ARSH, execPkg::ARSHI:
			begin
				result = $signed(a) >>> b;
			end
		endcase

		flags.zero = setsZero && (result == '0);
	end

endmodule

//--- logic/regFile.sv
module regFile
(
	input  logic clk,
	input  logic rstN,
	input  execPkg::regIdx_t rdAddrA,
	input  execPkg::regIdx_t rdAddrB,
	output execPkg::dataWord_t rdDataA,
	output execPkg::dataWord_t rdDataB,
	input  logic wrEn,
	input  execPkg::regIdx_t wrAddr,
	input  execPkg::dataWord_t wrData
);

	execPkg::dataWord_t regs [execPkg::regCount];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			// Every register starts at zero
			for (int i = 0; i < execPkg::regCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrEn)
		begin
			regs[wrAddr] <= wrData;
		end
	end

	// Read ports, no latency
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

//--- logic/operandSelect.sv
module operandSelect
(
	input  execPkg::instrPkt_t instr,
	input  execPkg::dataWord_t regB,
	output execPkg::dataWord_t opB,
	output logic writesBack
);

	logic isImm;
	logic signExt;
	execPkg::dataWord_t immExt;

	////////////////////////////////////////////////////////////
	// Immediate extension
	////////////////////////////////////////////////////////////

	assign isImm = instr.opcode inside {execPkg::ADDI, execPkg::ADDUI,
		execPkg::ADDCI, execPkg::ADDCUI, execPkg::SUBI, execPkg::CMPI,
		execPkg::CMPUI, execPkg::ANDI, execPkg::ORI, execPkg::XORI,
		execPkg::LSHI, execPkg::RSHI, execPkg::ALSHI, execPkg::ARSHI};

	// Signed forms only, the rest zero-extend
	assign signExt = instr.opcode inside {execPkg::ADDI, execPkg::ADDCI,
		execPkg::SUBI, execPkg::CMPI};

	assign immExt = signExt
		? {{(execPkg::dataWidth-execPkg::immWidth){instr.imm[execPkg::immWidth-1]}},
			instr.imm}
		: {{(execPkg::dataWidth-execPkg::immWidth){1'b0}}, instr.imm};

	assign opB = isImm ? immExt : regB;

	// Compares, NOP and unknown opcodes leave the register file alone
	always_comb
	begin
		case (instr.opcode)
			execPkg::ADD, execPkg::ADDI, execPkg::ADDU, execPkg::ADDUI,
			execPkg::ADDC, execPkg::ADDCI, execPkg::ADDCU, execPkg::ADDCUI,
			execPkg::SUB, execPkg::SUBI,
			execPkg::AND, execPkg::ANDI, execPkg::OR, execPkg::ORI,
			execPkg::XOR, execPkg::XORI, execPkg::NOT,
			execPkg::LSH, execPkg::LSHI, execPkg::RSH, execPkg::RSHI,
			execPkg::ALSH, execPkg::ALSHI, execPkg::ARSH, execPkg::ARSHI:
				writesBack = 1'b1;
			default:
				writesBack = 1'b0;
		endcase
	end

endmodule

//--- logic/issueControl.sv
module issueControl
(
	input  logic clk,
	input  logic rstN,
	input  logic instrReq,
	input  execPkg::instrPkt_t instr,
	output logic instrAck,
	output execPkg::instrPkt_t curInstr,
	input  logic writesBack,
	input  execPkg::dataWord_t aluResult,
	input  execPkg::flags_t aluFlags,
	output logic carryIn,
	output logic wrEn,
	output execPkg::regIdx_t wrAddr,
	output execPkg::dataWord_t wrData,
	output execPkg::resultPkt_t done
);

	typedef enum logic [1:0]
	{
		stateIdle,
		stateExec,
		stateAck
	} state_t;

	state_t state;
	execPkg::flags_t status;
	logic isCompare;
	logic updateFlags;

	////////////////////////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= stateIdle;
			instrAck <= 1'b0;
			done <= '0;
			status <= '0;
		end
		else
		begin
			case (state)
				stateIdle:
				begin
					if (instrReq)
					begin
						state <= stateExec;
					end
				end
				// One cycle to execute, then commit and acknowledge
				stateExec:
				begin
					state <= stateAck;
					instrAck <= 1'b1;
					done <= '{value: aluResult, flags: aluFlags, wrote: writesBack};
					if (updateFlags)
					begin
						status <= aluFlags;
					end
				end
				// Hold the result until the issuer lets go
				stateAck:
				begin
					if (!instrReq)
					begin
						state <= stateIdle;
						instrAck <= 1'b0;
					end
				end
				default:
				begin
					state <= stateIdle;
				end
			endcase
		end
	end

	// Instruction capture on acceptance
	always_ff @(posedge clk)
	begin
		if (state == stateIdle && instrReq)
		begin
			curInstr <= instr;
		end
	end

	////////////////////////////////////////////////////////////
	// Commit
	////////////////////////////////////////////////////////////

	assign isCompare = curInstr.opcode inside {execPkg::CMP, execPkg::CMPI,
		execPkg::CMPU, execPkg::CMPUI};

	// NOP and unknown opcodes keep the old flags
	assign updateFlags = writesBack || isCompare;

	assign carryIn = status.carry;

	assign wrEn = (state == stateExec) && writesBack;
	assign wrAddr = curInstr.rDest;
	assign wrData = aluResult;

endmodule

//--- logic/execCore.sv
module execCore
(
	input  logic clk,
	input  logic rstN,
	input  logic instrReq,
	input  execPkg::instrPkt_t instr,
	output logic instrAck,
	output execPkg::resultPkt_t done
);

	execPkg::instrPkt_t curInstr;
	execPkg::dataWord_t rdDataA;
	execPkg::dataWord_t rdDataB;
	execPkg::dataWord_t opB;
	logic writesBack;
	execPkg::dataWord_t aluResult;
	execPkg::flags_t aluFlags;
	logic carryIn;
	logic wrEn;
	execPkg::regIdx_t wrAddr;
	execPkg::dataWord_t wrData;

	////////////////////////////////////////////////////////////
	// Control and state
	////////////////////////////////////////////////////////////

	issueControl i_issueControl
	(
		.clk        (clk),
		.rstN       (rstN),
		.instrReq   (instrReq),
		.instr      (instr),
		.instrAck   (instrAck),
		.curInstr   (curInstr),
		.writesBack (writesBack),
		.aluResult  (aluResult),
		.aluFlags   (aluFlags),
		.carryIn    (carryIn),
		.wrEn       (wrEn),
		.wrAddr     (wrAddr),
		.wrData     (wrData),
		.done       (done)
	);

	// Destination doubles as operand A
	regFile i_regFile
	(
		.clk     (clk),
		.rstN    (rstN),
		.rdAddrA (curInstr.rDest),
		.rdAddrB (curInstr.rSrc),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData)
	);

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	operandSelect i_operandSelect
	(
		.instr      (curInstr),
		.regB       (rdDataB),
		.opB        (opB),
		.writesBack (writesBack)
	);

	alu i_alu
	(
		.a       (rdDataA),
		.b       (opB),
		.carryIn (carryIn),
		.opcode  (curInstr.opcode),
		.result  (aluResult),
		.flags   (aluFlags)
	);

endmodule

//--- test/execCore_tb.sv
module execCore_tb;

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic rstN;
	logic instrReq;
	execPkg::instrPkt_t instr;
	logic instrAck;
	execPkg::resultPkt_t done;

	// Test table, one entry per line of the test file
	string names [$];
	execPkg::instrPkt_t instrs [$];
	execPkg::resultPkt_t expects [$];

	integer seed = 19;
	int cycles = 0;
	int cycleLimit = 0;

	execCore i_execCore
	(
		.clk      (clk),
		.rstN     (rstN),
		.instrReq (instrReq),
		.instr    (instr),
		.instrAck (instrAck),
		.done     (done)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#10 clk = ~clk;
		end
	end

	// Watchdog sized from the test count
	initial
	begin
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycleLimit > 0 && cycles > cycleLimit)
			begin
				abortRun($sformatf("Timeout after %0d cycles, the run did not finish", cycles));
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Failure reporting and compares
	////////////////////////////////////////////////////////////

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string testName, input execPkg::dataWord_t expected,
		input execPkg::dataWord_t actual);
		if (actual !== expected)
		begin
			abortRun($sformatf("[FAIL] %s value expected %h actual %h",
				testName, expected, actual));
		end
	endtask

	task automatic checkFlags(input string testName, input execPkg::flags_t expected,
		input execPkg::flags_t actual);
		if (actual !== expected)
		begin
			abortRun($sformatf("[FAIL] %s flags expected %b actual %b",
				testName, expected, actual));
		end
	endtask

	task automatic checkWrote(input string testName, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			abortRun($sformatf("[FAIL] %s wrote expected %b actual %b",
				testName, expected, actual));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test file and handshake
	////////////////////////////////////////////////////////////

	task automatic loadTests();
		int fd;
		int count;
		int ch;
		string name;
		logic [7:0] op;
		execPkg::regIdx_t rd;
		execPkg::regIdx_t rs;
		logic [execPkg::immWidth-1:0] imm;
		execPkg::dataWord_t value;
		logic [4:0] flagBits;
		logic wrote;
		execPkg::instrPkt_t pkt;
		execPkg::resultPkt_t expected;
		fd = $fopen("test/execCoreTests.txt", "r");
		if (fd == 0)
		begin
			abortRun("Could not open test/execCoreTests.txt");
		end
		else
		begin
			while ($fscanf(fd, "%s", name) == 1)
			begin
				if (name.getc(0) == "#")
				begin
					// Skip the rest of a comment line
					ch = $fgetc(fd);
					while (ch != "\n" && ch != -1)
					begin
						ch = $fgetc(fd);
					end
				end
				else
				begin
					count = $fscanf(fd, "%h %h %h %h %h %b %b",
						op, rd, rs, imm, value, flagBits, wrote);
					if (count != 7)
					begin
						abortRun($sformatf("Test line %s is incomplete", name));
					end
					else
					begin
						pkt.opcode = execPkg::opcode_t'(op);
						pkt.rDest = rd;
						pkt.rSrc = rs;
						pkt.imm = imm;
						expected.value = value;
						expected.flags = flagBits;
						expected.wrote = wrote;
						names.push_back(name);
						instrs.push_back(pkt);
						expects.push_back(expected);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic runTest(input int idx);
		int delay;
		int hold;
		int edges;
		execPkg::resultPkt_t seen;
		delay = {$random(seed)} % 4;
		hold = {$random(seed)} % 4;
		repeat (delay) @(negedge clk);
		instr = instrs[idx];
		instrReq = 1'b1;
		edges = 0;
		while (!instrAck)
		begin
			@(negedge clk);
			edges++;
		end
		if (edges != 2)
		begin
			abortRun($sformatf("%s acknowledged %0d rising edges after the request, not 2",
				names[idx], edges));
		end
		seen = done;
		checkValue(names[idx], expects[idx].value, seen.value);
		checkFlags(names[idx], expects[idx].flags, seen.flags);
		checkWrote(names[idx], expects[idx].wrote, seen.wrote);
		// Back-pressure, request held past the acknowledge
		repeat (hold)
		begin
			@(negedge clk);
			if (instrAck !== 1'b1)
			begin
				abortRun($sformatf("%s lost its acknowledge while the request was held",
					names[idx]));
			end
			if (done !== seen)
			begin
				abortRun($sformatf("%s result changed while acknowledged", names[idx]));
			end
		end
		instrReq = 1'b0;
		@(negedge clk);
		if (instrAck !== 1'b0)
		begin
			abortRun($sformatf("%s acknowledge did not fall after the request dropped",
				names[idx]));
		end
	endtask

	initial
	begin
		instrReq = 1'b0;
		instr = '0;
		rstN = 1'b0;
		loadTests();
		cycleLimit = names.size() * 12 + 20;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		if (instrAck !== 1'b0 || done !== '0)
		begin
			abortRun("Acknowledge or result was not cleared by reset");
		end
		for (int i = 0; i < names.size(); i++)
		begin
			runTest(i);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

//--- test/execCoreTests.txt
# name opcode(hex) rDest(hex) rSrc(hex) imm(hex) value(hex) flags(bin zcoln) wrote
# Registers start at zero, so values are built with ORI and LSHI
ori_first_r1      20 1 0 5a 005a 00000 1
ori_zero_r2       20 2 0 00 0000 10000 1
ori_low_r2        20 2 0 ff 00ff 00000 1
lshi_r2           80 2 0 08 ff00 00000 1
ori_fill_r2       20 2 0 ff ffff 00000 1
ori_one_r3        20 3 0 01 0001 00000 1
addu_carry        06 2 3 00 0000 11000 1
addcu_with_carry  04 3 3 00 0003 00000 1
addcu_no_carry    04 3 3 00 0006 00000 1
ori_r4            20 4 0 7f 007f 00000 1
lshi_r4           80 4 0 08 7f00 00000 1
ori_r5            20 5 0 40 0040 00000 1
lshi_r5           80 5 0 08 4000 00000 1
add_overflow      05 4 5 00 bf00 00100 1
sub_equal         09 5 5 00 0000 10000 1
addi_negative     50 3 0 fe 0004 00000 1
cmp_signed        0b 4 3 00 0000 00011 0
cmpu_unsigned     08 4 3 00 0000 00000 0
ori_read_r4       20 4 0 00 bf00 00000 1
ori_r6            20 6 0 f0 00f0 00000 1
and_r6_r1         01 6 1 00 0050 00000 1
and_zero          01 6 3 00 0000 10000 1
or_r6_r1          02 6 1 00 005a 00000 1
xor_zero          03 6 1 00 0000 10000 1
not_r6            0f 6 0 00 ffff 00000 1
ori_r7            20 7 0 81 0081 00000 1
lsh_r7            84 7 3 00 0810 00000 1
rsh_r7            85 7 3 00 0081 00000 1
alsh_r7           86 7 3 00 0810 00000 1
arsh_positive     87 7 3 00 0081 00000 1
arsh_negative     87 4 3 00 fbf0 00000 1
ori_r8            20 8 0 10 0010 00000 1
arsh_count16      87 4 8 00 ffff 00000 1
lsh_count16       84 7 8 00 0000 00000 1
ori_r9            20 9 0 01 0001 00000 1
addu_carry_again  06 6 9 00 0000 11000 1
nop               00 0 0 00 0000 00000 0
addcu_after_nop   04 9 9 00 0003 00000 1
unknown_opcode    ff 0 0 00 0000 00000 0
ori_after_nop     20 1 0 00 005a 00000 1

//--- all.f
logic/execPkg.sv
logic/alu.sv
logic/regFile.sv
logic/operandSelect.sv
logic/issueControl.sv
logic/execCore.sv
test/execCore_tb.sv

//--- Bender.yml
package:
  name: execCore

sources:
  # Design, package first
  - logic/execPkg.sv
  - logic/alu.sv
  - logic/regFile.sv
  - logic/operandSelect.sv
  - logic/issueControl.sv
  - logic/execCore.sv
  # Testbench
  - target: test
    files:
      - test/execCore_tb.sv
